// File: source/wordPkg.sv
package wordPkg;

  // Machine word geometry
  // Bit 0 is the most significant bit, as numbered on the prints
  localparam int WORD_WIDTH = 36;
  localparam int HALF_WIDTH = WORD_WIDTH / 2;

  // Left half occupies bits 0..17, right half bits 18..35
  localparam int LEFT_MSB  = 0;
  localparam int RIGHT_MSB = HALF_WIDTH;

  // Full machine word
  typedef logic [0:WORD_WIDTH-1] word_t;

  // Half word, used when the channel register swaps halves
  typedef logic [0:HALF_WIDTH-1] half_t;

  // Clear value for word registers
  localparam word_t WORD_ZERO = '0;

  // Exchange left and right halves of a word
  function automatic word_t swapHalves(input word_t w);
    half_t leftHalf;
    half_t rightHalf;
    leftHalf  = w[LEFT_MSB +: HALF_WIDTH];
    rightHalf = w[RIGHT_MSB +: HALF_WIDTH];
    return {rightHalf, leftHalf};
  endfunction

endpackage

// File: source/mboxPkg.sv
package mboxPkg;

  // Memory-buffer register bank
  localparam int NUM_MB       = 4;
  localparam int MB_IDX_WIDTH = 2;

  // Channel buffer RAM
  localparam int CH_BUF_DEPTH  = 128;
  localparam int CH_ADDR_WIDTH = 7;

  // Channel command word buffer
  localparam int CCW_DEPTH      = 4;
  localparam int CCW_ADDR_WIDTH = 2;

  // Memory-buffer input select
  // Upper two bits pick the source group; bit 0 picks the channel buffer
  // word over AR inside the AR group
  typedef enum logic [2:0] {
    SEL_CACHE   = 3'b000,
    SEL_AR      = 3'b010,
    SEL_CH_BUF  = 3'b011,
    SEL_MEM     = 3'b100,
    SEL_CCW_MIX = 3'b110
  } mbInSel_e;

  // Memory-to-cache source
  typedef enum logic [1:0] {
    M2C_AR     = 2'b00,
    M2C_MB     = 2'b01,
    M2C_MEM    = 2'b10,
    M2C_CH_REG = 2'b11
  } memToCacheSel_e;

  // Channel transfer sequencer
  typedef enum logic [1:0] {
    CH_IDLE,
    CH_T0,
    CH_T1,
    CH_T2
  } chState_e;

endpackage

// File: source/mbSourceSelect.sv
`timescale 1ns/1ps

module mbSourceSelect
  import wordPkg::*;
  import mboxPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      loadStrobe,
  input  logic                      nxm,
  input  mbInSel_e                  inSel,
  input  logic [MB_IDX_WIDTH-1:0]   mbLoadIdxIn,
  input  word_t                     cacheData,
  input  word_t                     ar,
  input  word_t                     memDataIn,
  input  word_t                     mb,
  input  word_t                     mbChBuf,
  input  logic                      ccwWrite,
  input  logic [CCW_ADDR_WIDTH-1:0] ccwAddr,
  input  word_t                     ccwIn,
  input  logic                      mixMbSel,
  output word_t                     mbIn,
  output logic                      mbLoad,
  output logic [MB_IDX_WIDTH-1:0]   mbLoadIdx,
  output word_t                     ccwMix
);

  // Channel command word buffer
  word_t ccwBuf [0:CCW_DEPTH-1];

  always_ff @(posedge clk) begin
    if (ccwWrite) begin
      ccwBuf[ccwAddr] <= ccwIn;
    end
  end

  // CCW mix takes either the current MB or the addressed buffer word
  assign ccwMix = mixMbSel ? mb : ccwBuf[ccwAddr];

  always_comb begin
    case (inSel)
      SEL_CACHE:   mbIn = cacheData;
      SEL_AR:      mbIn = ar;
      SEL_CH_BUF:  mbIn = mbChBuf;
      SEL_MEM:     mbIn = memDataIn;
      SEL_CCW_MIX: mbIn = ccwMix;
      default:     mbIn = WORD_ZERO;
    endcase
  end

  // A reference to non-existent memory must not disturb the MB registers
  assign mbLoad    = loadStrobe & ~nxm;
  assign mbLoadIdx = mbLoadIdxIn;

  // The select code must name a real source whenever a load is offered
  assert property (@(posedge clk) disable iff (rst)
    loadStrobe |-> inSel inside {SEL_CACHE, SEL_AR, SEL_CH_BUF, SEL_MEM, SEL_CCW_MIX})
    else $error("mbSourceSelect: undefined inSel %0b with loadStrobe", inSel);

endmodule

// File: source/mbRegisterBank.sv
`timescale 1ns/1ps

module mbRegisterBank
  import wordPkg::*;
  import mboxPkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  input  word_t                   mbIn,
  input  logic                    mbLoad,
  input  logic [MB_IDX_WIDTH-1:0] mbLoadIdx,
  input  logic                    selStrobe,
  input  logic [MB_IDX_WIDTH-1:0] selIdx,
  output word_t                   mb,
  output logic                    mbParOdd
);

  // MB0..MB3
  word_t mbRegs [0:NUM_MB-1];

  // Bank select, loaded only on selStrobe
  logic [MB_IDX_WIDTH-1:0] bankSel;

  genvar i;
  generate
    for (i = 0; i < NUM_MB; i++) begin : gMbReg
      always_ff @(posedge clk) begin
        if (rst) begin
          mbRegs[i] <= WORD_ZERO;
        end else if (mbLoad && (mbLoadIdx == MB_IDX_WIDTH'(i))) begin
          mbRegs[i] <= mbIn;
        end
      end
    end
  endgenerate

  always_ff @(posedge clk) begin
    if (rst) begin
      bankSel <= '0;
    end else if (selStrobe) begin
      bankSel <= selIdx;
    end
  end

  assign mb = mbRegs[bankSel];

  // Odd parity over the selected word
  assign mbParOdd = ^mb;

  // Register outputs are cleared by reset, so X here means a broken path
  assert property (@(posedge clk) disable iff (rst)
    !$isunknown(mb))
    else $error("mbRegisterBank: mb is unknown");

endmodule

// File: source/channelPath.sv
`timescale 1ns/1ps

module channelPath
  import wordPkg::*;
  import mboxPkg::*;
(
  input  logic                     clk,
  input  logic                     rst,
  input  word_t                    mb,
  input  word_t                    ar,
  input  word_t                    memDataIn,
  input  logic                     chStart,
  input  logic [CH_ADDR_WIDTH-1:0] chAddr,
  input  logic                     chBufWrite,
  input  logic                     chBufFromMb,
  input  logic                     chRegLoad,
  input  logic                     chReverse,
  input  word_t                    cbusIn,
  input  logic                     cbusHold,
  input  logic                     m2cEnable,
  input  memToCacheSel_e           m2cSel,
  output word_t                    mbChBuf,
  output word_t                    cbusOut,
  output word_t                    memToCache,
  output logic                     chDone
);

  word_t    chBuf [0:CH_BUF_DEPTH-1];
  word_t    chBufIn;
  word_t    chBufRd;
  word_t    chReg;
  chState_e state;

  // Channel buffer write data comes from MB or the channel register
  assign chBufIn = chBufFromMb ? mb : chReg;

  // Read is captured only on a start so the word stays put for the sequence
  always_ff @(posedge clk) begin
    if (chBufWrite) begin
      chBuf[chAddr] <= chBufIn;
    end
    if (chStart) begin
      chBufRd <= chBuf[chAddr];
    end
  end

  // Channel register, halves swapped for reverse transfers
  always_ff @(posedge clk) begin
    if (rst) begin
      chReg <= WORD_ZERO;
    end else if (chRegLoad) begin
      chReg <= chReverse ? swapHalves(cbusIn) : cbusIn;
    end
  end

  // Transfer sequencer T0 -> T1 -> T2
  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= CH_IDLE;
      cbusOut <= WORD_ZERO;
      mbChBuf <= WORD_ZERO;
    end else begin
      case (state)
        CH_IDLE: if (chStart) state <= CH_T0;
        CH_T0: begin
          // Bus output keeps its old word while the channel holds it
          if (!cbusHold) cbusOut <= chBufRd;
          state <= CH_T1;
        end
        CH_T1: begin
          mbChBuf <= chBufRd;
          state   <= CH_T2;
        end
        default: state <= CH_IDLE;
      endcase
    end
  end

  assign chDone = (state == CH_T2);

  always_comb begin
    memToCache = WORD_ZERO;
    if (m2cEnable) begin
      case (m2cSel)
        M2C_AR:     memToCache = ar;
        M2C_MB:     memToCache = mb;
        M2C_MEM:    memToCache = memDataIn;
        M2C_CH_REG: memToCache = chReg;
        default:    memToCache = WORD_ZERO;
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    chStart |-> (state == CH_IDLE))
    else $error("channelPath: chStart while sequencer busy");

  // RAM port is shared between the read on start and the write
  assert property (@(posedge clk) disable iff (rst)
    !(chStart && chBufWrite))
    else $error("channelPath: chStart and chBufWrite together");

endmodule

// File: source/memBuffer.sv
`timescale 1ns/1ps

module memBuffer
  import wordPkg::*;
  import mboxPkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      loadStrobe,
  input  logic                      nxm,
  input  mbInSel_e                  inSel,
  input  logic [MB_IDX_WIDTH-1:0]   mbLoadIdxIn,
  input  word_t                     cacheData,
  input  word_t                     ar,
  input  word_t                     memDataIn,
  input  logic                      ccwWrite,
  input  logic [CCW_ADDR_WIDTH-1:0] ccwAddr,
  input  word_t                     ccwIn,
  input  logic                      mixMbSel,
  input  logic                      selStrobe,
  input  logic [MB_IDX_WIDTH-1:0]   selIdx,
  input  logic                      chStart,
  input  logic [CH_ADDR_WIDTH-1:0]  chAddr,
  input  logic                      chBufWrite,
  input  logic                      chBufFromMb,
  input  logic                      chRegLoad,
  input  logic                      chReverse,
  input  word_t                     cbusIn,
  input  logic                      cbusHold,
  input  logic                      m2cEnable,
  input  memToCacheSel_e            m2cSel,
  output word_t                     ccwMix,
  output word_t                     mb,
  output logic                      mbParOdd,
  output word_t                     mbChBuf,
  output word_t                     cbusOut,
  output word_t                     memToCache,
  output logic                      chDone
);

  word_t                   mbIn;
  logic                    mbLoad;
  logic [MB_IDX_WIDTH-1:0] mbLoadIdx;

  mbSourceSelect u_source (
    .clk, .rst, .loadStrobe, .nxm, .inSel, .mbLoadIdxIn,
    .cacheData, .ar, .memDataIn, .mb, .mbChBuf,
    .ccwWrite, .ccwAddr, .ccwIn, .mixMbSel,
    .mbIn, .mbLoad, .mbLoadIdx, .ccwMix
  );

  mbRegisterBank u_bank (
    .clk, .rst, .mbIn, .mbLoad, .mbLoadIdx,
    .selStrobe, .selIdx, .mb, .mbParOdd
  );

  channelPath u_channel (
    .clk, .rst, .mb, .ar, .memDataIn,
    .chStart, .chAddr, .chBufWrite, .chBufFromMb,
    .chRegLoad, .chReverse, .cbusIn, .cbusHold,
    .m2cEnable, .m2cSel,
    .mbChBuf, .cbusOut, .memToCache, .chDone
  );

endmodule

// File: verif/memBufferTb.sv
`timescale 1ns/1ps

module memBufferTb
  import wordPkg::*;
  import mboxPkg::*;
();

  localparam int NUM_OPS         = 300;
  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int DONE_WAIT       = 8;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 8 + 200;
  localparam logic [31:0] SEED   = 32'h78b6_1b59;

  logic clk = 1'b0;
  logic rst;
  logic loadStrobe, nxm, ccwWrite, mixMbSel, selStrobe;
  logic chStart, chBufWrite, chBufFromMb, chRegLoad, chReverse, cbusHold, m2cEnable;
  mbInSel_e inSel;
  memToCacheSel_e m2cSel;
  logic [MB_IDX_WIDTH-1:0] mbLoadIdxIn, selIdx;
  logic [CCW_ADDR_WIDTH-1:0] ccwAddr;
  logic [CH_ADDR_WIDTH-1:0] chAddr;
  word_t cacheData, ar, memDataIn, ccwIn, cbusIn;
  word_t ccwMix, mb, mbChBuf, cbusOut, memToCache;
  logic mbParOdd, chDone;

  logic [31:0] rngState;
  int errors = 0;
  int opCount = 0;
  int xferCount = 0;

  memBuffer u_dut (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Reference model state
  word_t regsModel [0:NUM_MB-1];
  word_t ccwModel [0:CCW_DEPTH-1];
  word_t chBufModel [0:CH_BUF_DEPTH-1];
  logic [MB_IDX_WIDTH-1:0] bankSelModel;
  word_t chRegModel, xferWord, expCbusOut, expMbChBuf;
  word_t expMb, expMbIn, expM2c, expCcwMix;
  int seqStep;

  assign expMb = regsModel[bankSelModel];

  assign expCcwMix = mixMbSel ? expMb : ccwModel[ccwAddr];

  always_comb begin
    case (inSel)
      SEL_CACHE:   expMbIn = cacheData;
      SEL_AR:      expMbIn = ar;
      SEL_MEM:     expMbIn = memDataIn;
      SEL_CH_BUF:  expMbIn = expMbChBuf;
      SEL_CCW_MIX: expMbIn = expCcwMix;
      default:     expMbIn = WORD_ZERO;
    endcase
  end

  always_comb begin
    expM2c = WORD_ZERO;
    if (m2cEnable) begin
      case (m2cSel)
        M2C_AR:  expM2c = ar;
        M2C_MB:  expM2c = expMb;
        M2C_MEM: expM2c = memDataIn;
        default: expM2c = chRegModel;
      endcase
    end
  end

  always @(posedge clk) begin
    if (rst) begin
      for (int k = 0; k < NUM_MB; k++) begin
        regsModel[k] <= WORD_ZERO;
      end
      bankSelModel <= '0;
      chRegModel   <= WORD_ZERO;
      expCbusOut   <= WORD_ZERO;
      expMbChBuf   <= WORD_ZERO;
      seqStep      <= 0;
    end else begin
      // Non-existent memory blocks the load entirely
      if (loadStrobe && !nxm) begin
        regsModel[mbLoadIdxIn] <= expMbIn;
      end
      if (selStrobe) begin
        bankSelModel <= selIdx;
      end
      if (ccwWrite) begin
        ccwModel[ccwAddr] <= ccwIn;
      end
      if (chBufWrite) begin
        chBufModel[chAddr] <= chBufFromMb ? expMb : chRegModel;
      end
      if (chRegLoad) begin
        chRegModel <= chReverse ?
          {cbusIn[HALF_WIDTH:WORD_WIDTH-1], cbusIn[0:HALF_WIDTH-1]} : cbusIn;
      end
      // Start, bus output, MB channel word, done
      case (seqStep)
        0: begin
          if (chStart) begin
            xferWord <= chBufModel[chAddr];
            seqStep  <= 1;
          end
        end
        1: begin
          if (!cbusHold) expCbusOut <= xferWord;
          seqStep <= 2;
        end
        2: begin
          expMbChBuf <= xferWord;
          seqStep    <= 3;
        end
        default: seqStep <= 0;
      endcase
    end
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  function automatic word_t randomWord();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = nextRandom();
    lo = nextRandom();
    return {hi[31:28], lo};
  endfunction

  function automatic mbInSel_e randomSource();
    logic [31:0] r;
    r = nextRandom();
    case (r[31:16] % 16'd5)
      16'd0:   return SEL_CACHE;
      16'd1:   return SEL_AR;
      16'd2:   return SEL_MEM;
      16'd3:   return SEL_CH_BUF;
      default: return SEL_CCW_MIX;
    endcase
  endfunction

  function automatic logic oddParity(input word_t w);
    logic p;
    p = 1'b0;
    for (int k = 0; k < WORD_WIDTH; k++) begin
      p = p ^ w[k];
    end
    return p;
  endfunction

  // Checks against the model
  assert property (@(posedge clk)
    $fell(rst) |-> (mb == WORD_ZERO && !chDone && memToCache == WORD_ZERO))
    else begin
      errors++;
      $display("Fail %0t: outputs not cleared after reset", $time);
    end

  assert property (@(posedge clk) disable iff (rst) mb == expMb)
    else begin
      errors++;
      $display("Fail %0t: mb %h, expected %h", $time, mb, expMb);
    end

  assert property (@(posedge clk) disable iff (rst) mbParOdd == oddParity(expMb))
    else begin
      errors++;
      $display("Fail %0t: mbParOdd %b for mb %h", $time, mbParOdd, expMb);
    end

  // Unwritten CCW entries are unknown in both the DUT and the model
  assert property (@(posedge clk) disable iff (rst) ccwMix === expCcwMix)
    else begin
      errors++;
      $display("Fail %0t: ccwMix %h, expected %h", $time, ccwMix, expCcwMix);
    end

  assert property (@(posedge clk) disable iff (rst) chDone == (seqStep == 3))
    else begin
      errors++;
      $display("Fail %0t: chDone %b in transfer step %0d", $time, chDone, seqStep);
    end

  assert property (@(posedge clk) disable iff (rst) cbusOut == expCbusOut)
    else begin
      errors++;
      $display("Fail %0t: cbusOut %h, expected %h", $time, cbusOut, expCbusOut);
    end

  assert property (@(posedge clk) disable iff (rst) mbChBuf == expMbChBuf)
    else begin
      errors++;
      $display("Fail %0t: mbChBuf %h, expected %h", $time, mbChBuf, expMbChBuf);
    end

  assert property (@(posedge clk) disable iff (rst) memToCache == expM2c)
    else begin
      errors++;
      $display("Fail %0t: memToCache %h, expected %h", $time, memToCache, expM2c);
    end

  // Ends the current cycle, drops strobes, refreshes data and levels
  task automatic nextCycle();
    logic [31:0] r;
    @(negedge clk);
    loadStrobe = 1'b0;
    selStrobe  = 1'b0;
    ccwWrite   = 1'b0;
    chStart    = 1'b0;
    chBufWrite = 1'b0;
    chRegLoad  = 1'b0;
    r = nextRandom();
    nxm         = r[31];
    mixMbSel    = r[30];
    m2cEnable   = r[29];
    chBufFromMb = r[28];
    chReverse   = r[27];
    m2cSel      = memToCacheSel_e'(r[26:25]);
    ccwAddr     = r[24:23];
    selIdx      = r[22:21];
    mbLoadIdxIn = r[20:19];
    chAddr      = r[18:12];
    cacheData   = randomWord();
    ar          = randomWord();
    memDataIn   = randomWord();
    ccwIn       = randomWord();
    cbusIn      = randomWord();
  endtask

  task automatic loadWord(input mbInSel_e src, input logic withSelect);
    loadStrobe = 1'b1;
    inSel      = src;
    selStrobe  = withSelect;
    nextCycle();
  endtask

  task automatic writeCcwThenMix();
    logic [CCW_ADDR_WIDTH-1:0] a;
    a = ccwAddr;
    ccwWrite = 1'b1;
    nextCycle();
    loadStrobe = 1'b1;
    nxm        = 1'b0;
    inSel      = SEL_CCW_MIX;
    ccwAddr    = a;
    selStrobe  = 1'b1;
    selIdx     = mbLoadIdxIn;
    nextCycle();
  endtask

  task automatic runTransfer();
    logic [CH_ADDR_WIDTH-1:0] a;
    logic [31:0] r;
    int waited;
    chRegLoad = 1'b1;
    nextCycle();
    a = chAddr;
    chBufWrite = 1'b1;
    nextCycle();
    r = nextRandom();
    chStart  = 1'b1;
    chAddr   = a;
    cbusHold = r[31];
    waited   = 0;
    nextCycle();
    while (!chDone && waited < DONE_WAIT) begin
      nextCycle();
      waited++;
    end
    if (!chDone) begin
      errors++;
      $display("Channel transfer from address %0d never signalled done", a);
    end
    cbusHold   = 1'b0;
    loadStrobe = 1'b1;
    nxm        = 1'b0;
    inSel      = SEL_CH_BUF;
    selStrobe  = 1'b1;
    selIdx     = mbLoadIdxIn;
    nextCycle();
    xferCount++;
  endtask

  task automatic loadChReg();
    chRegLoad = 1'b1;
    nextCycle();
    m2cEnable = 1'b1;
    m2cSel    = M2C_CH_REG;
    nextCycle();
  endtask

  initial begin
    logic [31:0] r;
    rngState    = SEED;
    rst         = 1'b1;
    loadStrobe  = 1'b0;
    nxm         = 1'b0;
    inSel       = SEL_CACHE;
    mbLoadIdxIn = '0;
    cacheData   = WORD_ZERO;
    ar          = WORD_ZERO;
    memDataIn   = WORD_ZERO;
    ccwWrite    = 1'b0;
    ccwAddr     = '0;
    ccwIn       = WORD_ZERO;
    mixMbSel    = 1'b0;
    selStrobe   = 1'b0;
    selIdx      = '0;
    chStart     = 1'b0;
    chAddr      = '0;
    chBufWrite  = 1'b0;
    chBufFromMb = 1'b0;
    chRegLoad   = 1'b0;
    chReverse   = 1'b0;
    cbusIn      = WORD_ZERO;
    cbusHold    = 1'b0;
    m2cEnable   = 1'b0;
    m2cSel      = M2C_AR;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    nextCycle();
    // CCW buffer has no reset, fill it before any mix load
    for (int a = 0; a < CCW_DEPTH; a++) begin
      ccwWrite = 1'b1;
      ccwAddr  = CCW_ADDR_WIDTH'(a);
      nextCycle();
    end
    for (int i = 0; i < NUM_OPS; i++) begin
      r = nextRandom();
      case (r[31:29])
        3'd0, 3'd1, 3'd2: loadWord(randomSource(), r[28]);
        3'd3: begin
          selStrobe = 1'b1;
          nextCycle();
        end
        3'd4: writeCcwThenMix();
        3'd5: runTransfer();
        default: loadChReg();
      endcase
      opCount++;
    end
    nextCycle();
    $display("Operations %0d, channel transfers %0d, errors %0d",
      opCount, xferCount, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before all operations ran",
      WATCHDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

// File: build.f
source/wordPkg.sv
source/mboxPkg.sv
source/mbSourceSelect.sv
source/mbRegisterBank.sv
source/channelPath.sv
source/memBuffer.sv
verif/memBufferTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memBufferTb
FILELIST  = build.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Test OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
